/* common/mem_pkg.sv */
// shared definitions for the memory subsystem of the simulation environment
// holds the address map, the request and response structs and the register offsets
// every RAM, router and register module imports this package in its header

package mem_pkg;

  // width of the RAM byte address, which gives a 4 KiB RAM by default
  localparam int RAM_ADDR_WIDTH_DEF = 12;

  // the memory-mapped registers sit in a small window far above the RAM
  localparam logic [31:0] MMIO_BASE = 32'h1000_0000;
  localparam logic [31:0] MMIO_SPAN = 32'd16;

  // number of address bits needed to pick a register inside the window
  localparam int MMIO_OFS_WIDTH = $clog2(MMIO_SPAN);

  // byte offsets of the registers relative to MMIO_BASE
  localparam logic [MMIO_OFS_WIDTH-1:0] CONSOLE_OFS = 4'h0;
  localparam logic [MMIO_OFS_WIDTH-1:0] EXIT_OFS    = 4'h4;
  localparam logic [MMIO_OFS_WIDTH-1:0] CYCLE_OFS   = 4'h8;

  // target of a data access as decoded by the router
  typedef enum logic [1:0] {
    SEL_RAM  = 2'd0,
    SEL_MMIO = 2'd1,
    SEL_NONE = 2'd2
  } mmio_sel_e;

  // instruction fetch request, the address is a plain byte address
  typedef struct packed {
    logic        en;
    logic [31:0] addr;
  } fetch_req_t;

  // data request with the usual strobes, there is no grant and no stall
  typedef struct packed {
    logic        en;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
  } data_req_t;

  // data response, err comes together with rvalid for an unmapped read
  typedef struct packed {
    logic        rvalid;
    logic [31:0] rdata;
    logic        err;
  } data_rsp_t;

  // data request as the RAM sees it, with a RAM-relative byte address
  typedef struct packed {
    logic                          en;
    logic                          we;
    logic [3:0]                    be;
    logic [RAM_ADDR_WIDTH_DEF-1:0] addr;
    logic [31:0]                   wdata;
  } ram_port_t;

endpackage

/* ram/dp_ram.sv */
// dual-port byte-addressed RAM for the core's simulation environment
// port A serves instruction fetch and only reads whole words
// port B serves data and writes with byte enables or reads whole words
// both ports return read data one cycle after the enable

`timescale 1ns/1ps

module dp_ram
  import mem_pkg::*;
#(
  parameter int ADDR_WIDTH = RAM_ADDR_WIDTH_DEF
) (
  input  logic                  clk_i,
  input  logic                  fetch_en_i,
  input  logic [ADDR_WIDTH-1:0] fetch_addr_i,
  output logic [31:0]           fetch_rdata_o,
  input  ram_port_t             data_port_i,
  output logic [31:0]           data_rdata_o
);

  localparam int NUM_BYTES = 2 ** ADDR_WIDTH;

  // the storage is a flat array of bytes and words are little endian
  logic [7:0] mem [NUM_BYTES];

  // word part of each address since the two lowest bits are forced to zero below
  logic [ADDR_WIDTH-3:0] fetch_word;
  logic [ADDR_WIDTH-3:0] data_word;

  // the RAM has no reset input, so this flag marks the first cycle with known enables
  logic inputs_seen_q = 1'b0;

  // the data port struct carries the package default width, so both must agree
  if (ADDR_WIDTH != RAM_ADDR_WIDTH_DEF) begin : g_width_check
    $error("dp_ram ADDR_WIDTH must equal the width of ram_port_t addr");
  end

  assign fetch_word = fetch_addr_i[ADDR_WIDTH-1:2];
  assign data_word  = data_port_i.addr[ADDR_WIDTH-1:2];

  // port A only updates when enabled, so the last fetched word stays visible
  always_ff @(posedge clk_i) begin
    if (fetch_en_i) begin
      for (int b = 0; b < 4; b++) begin
        fetch_rdata_o[8*b +: 8] <= mem[{fetch_word, 2'(b)}];
      end
    end
  end

  // port B writes only the enabled bytes or reads the whole word
  // nonblocking updates mean a same-cycle read on port A sees the old word
  always_ff @(posedge clk_i) begin
    if (data_port_i.en) begin
      if (data_port_i.we) begin
        for (int b = 0; b < 4; b++) begin
          if (data_port_i.be[b]) begin
            mem[{data_word, 2'(b)}] <= data_port_i.wdata[8*b +: 8];
          end
        end
      end else begin
        for (int b = 0; b < 4; b++) begin
          data_rdata_o[8*b +: 8] <= mem[{data_word, 2'(b)}];
        end
      end
    end
  end

  // once both enables have been driven to known values the checks below start
  always_ff @(posedge clk_i) begin
    if (!$isunknown({fetch_en_i, data_port_i.en})) begin
      inputs_seen_q <= 1'b1;
    end
  end

  // after the environment has come out of reset the strobes must stay known
  a_ctrl_known: assert property (@(posedge clk_i) disable iff (!inputs_seen_q)
    !$isunknown({fetch_en_i, data_port_i.en}) &&
    (!data_port_i.en || !$isunknown({data_port_i.we, data_port_i.be})))
    else $error("dp_ram control input is X");

  // a write that enables no byte points to a broken request upstream
  a_write_be: assert property (@(posedge clk_i) disable iff (!inputs_seen_q)
    (data_port_i.en && data_port_i.we) |-> (data_port_i.be != 4'b0000))
    else $error("dp_ram write with zero byte enables");

endmodule

/* source/data_port_router.sv */
// address decoder and read-data mux for the data port
// each request goes to the RAM, to the registers or, when unmapped, nowhere
// the target is registered so the read data can be picked one cycle later

`timescale 1ns/1ps

module data_port_router
  import mem_pkg::*;
#(
  parameter int RAM_ADDR_WIDTH = RAM_ADDR_WIDTH_DEF
) (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  data_req_t   req_i,
  output data_rsp_t   rsp_o,
  output ram_port_t   ram_req_o,
  input  logic [31:0] ram_rdata_i,
  output data_req_t   mmio_req_o,
  input  logic [31:0] mmio_rdata_i
);

  // first address above the RAM, one bit wider so a 32-bit RAM still fits
  localparam logic [32:0] RAM_LIMIT  = 33'd1 << RAM_ADDR_WIDTH;
  localparam logic [32:0] MMIO_LIMIT = {1'b0, MMIO_BASE} + {1'b0, MMIO_SPAN};

  mmio_sel_e sel;
  mmio_sel_e sel_q;
  logic      rd_q;

  // the RAM sits at address zero, the register window at MMIO_BASE
  always_comb begin
    if ({1'b0, req_i.addr} < RAM_LIMIT) begin
      sel = SEL_RAM;
    end else if (req_i.addr >= MMIO_BASE && {1'b0, req_i.addr} < MMIO_LIMIT) begin
      sel = SEL_MMIO;
    end else begin
      sel = SEL_NONE;
    end
  end

  // the RAM gets its low address bits only and aligns the word itself
  always_comb begin
    ram_req_o.en    = req_i.en && (sel == SEL_RAM);
    ram_req_o.we    = req_i.we;
    ram_req_o.be    = req_i.be;
    ram_req_o.addr  = RAM_ADDR_WIDTH_DEF'(req_i.addr[RAM_ADDR_WIDTH-1:0]);
    ram_req_o.wdata = req_i.wdata;
  end

  // the registers see the whole request and decode the offset themselves
  always_comb begin
    mmio_req_o    = req_i;
    mmio_req_o.en = req_i.en && (sel == SEL_MMIO);
  end

  // remember where a read went so the response can be taken from that target
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sel_q <= SEL_NONE;
      rd_q  <= 1'b0;
    end else begin
      sel_q <= sel;
      rd_q  <= req_i.en && !req_i.we;
    end
  end

  // an unmapped read returns zero and flags err with rvalid
  always_comb begin
    rsp_o.rvalid = rd_q;
    rsp_o.err    = rd_q && (sel_q == SEL_NONE);
    case (sel_q)
      SEL_RAM:  rsp_o.rdata = ram_rdata_i;
      SEL_MMIO: rsp_o.rdata = mmio_rdata_i;
      default:  rsp_o.rdata = 32'h0000_0000;
    endcase
  end

  // RAM and registers must never both see the same request
  a_one_target: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(ram_req_o.en && mmio_req_o.en))
    else $error("router enabled RAM and registers together");

  // every response belongs to a read issued on the edge before
  a_rvalid_after_read: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_o.rvalid |-> $past(req_i.en && !req_i.we))
    else $error("router rvalid without a read one cycle earlier");

endmodule

/* periph/mmio_regs.sv */
// memory-mapped registers behind the data port
// holds a console character output, a sticky test-exit register
// and a free-running cycle counter, read data comes one cycle after the request

`timescale 1ns/1ps

module mmio_regs
  import mem_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  data_req_t   req_i,
  output logic [31:0] rdata_o,
  output logic        console_valid_o,
  output logic [7:0]  console_char_o,
  output logic        exit_valid_o,
  output logic [31:0] exit_code_o
);

  logic [MMIO_OFS_WIDTH-1:0] ofs;
  logic                      console_wr;
  logic                      exit_wr;
  logic                      rd;

  logic        console_valid_q;
  logic [7:0]  console_char_q;
  logic        exit_valid_q;
  logic [31:0] exit_code_q;
  logic [31:0] cycle_q;
  logic [31:0] rdata_q;

  // the router only enables this block inside the window, so the low bits suffice
  assign ofs = req_i.addr[MMIO_OFS_WIDTH-1:0];

  // the console takes a character only when the lowest byte lane is written
  assign console_wr = req_i.en && req_i.we && (ofs == CONSOLE_OFS) && req_i.be[0];
  assign exit_wr    = req_i.en && req_i.we && (ofs == EXIT_OFS);
  assign rd         = req_i.en && !req_i.we;

  // the console strobe is a single-cycle pulse after each write
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      console_valid_q <= 1'b0;
      console_char_q  <= 8'h00;
    end else begin
      console_valid_q <= console_wr;
      if (console_wr) begin
        console_char_q <= req_i.wdata[7:0];
      end
    end
  end

  // only the first exit write counts, the flag then stays set until reset
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      exit_valid_q <= 1'b0;
      exit_code_q  <= 32'h0000_0000;
    end else if (exit_wr && !exit_valid_q) begin
      exit_valid_q <= 1'b1;
      exit_code_q  <= req_i.wdata;
    end
  end

  // the counter reads zero in the first cycle after reset and then counts up
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cycle_q <= 32'h0000_0000;
    end else begin
      cycle_q <= cycle_q + 32'd1;
    end
  end

  // reads sample the registers at the request edge
  // unused offsets read as zero and are not flagged
  always_ff @(posedge clk_i) begin
    if (rd) begin
      case (ofs)
        CONSOLE_OFS: rdata_q <= {24'h00_0000, console_char_q};
        EXIT_OFS:    rdata_q <= exit_code_q;
        CYCLE_OFS:   rdata_q <= cycle_q;
        default:     rdata_q <= 32'h0000_0000;
      endcase
    end
  end

  assign rdata_o         = rdata_q;
  assign console_valid_o = console_valid_q;
  assign console_char_o  = console_char_q;
  assign exit_valid_o    = exit_valid_q;
  assign exit_code_o     = exit_code_q;

  // two pulses in a row need two console writes on the two edges before
  a_console_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (console_valid_o && $past(console_valid_o)) |-> ($past(console_wr, 1) && $past(console_wr, 2)))
    else $error("console_valid_o held high without back-to-back writes");

endmodule

/* source/mem_subsys_top.sv */
// top level of the memory subsystem used by the core's simulation environment
// the fetch port reads the RAM directly, the data port goes through the router
// which reaches either the RAM or the memory-mapped registers

`timescale 1ns/1ps

module mem_subsys_top
  import mem_pkg::*;
#(
  parameter int RAM_ADDR_WIDTH = RAM_ADDR_WIDTH_DEF
) (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  fetch_req_t  fetch_req_i,
  output logic [31:0] fetch_rdata_o,
  input  data_req_t   data_req_i,
  output data_rsp_t   data_rsp_o,
  output logic        console_valid_o,
  output logic [7:0]  console_char_o,
  output logic        exit_valid_o,
  output logic [31:0] exit_code_o
);

  // data path from the router to the RAM
  ram_port_t   ram_req;
  logic [31:0] ram_rdata;

  // data path from the router to the registers
  data_req_t   mmio_req;
  logic [31:0] mmio_rdata;

  // fetch addresses are not decoded and simply wrap modulo the RAM size
  dp_ram #(
    .ADDR_WIDTH (RAM_ADDR_WIDTH)
  ) dp_ram_i (
    .clk_i         (clk_i),
    .fetch_en_i    (fetch_req_i.en),
    .fetch_addr_i  (fetch_req_i.addr[RAM_ADDR_WIDTH-1:0]),
    .fetch_rdata_o (fetch_rdata_o),
    .data_port_i   (ram_req),
    .data_rdata_o  (ram_rdata)
  );

  // the router adds no latency, it only steers and muxes the read data
  data_port_router #(
    .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH)
  ) data_port_router_i (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .req_i        (data_req_i),
    .rsp_o        (data_rsp_o),
    .ram_req_o    (ram_req),
    .ram_rdata_i  (ram_rdata),
    .mmio_req_o   (mmio_req),
    .mmio_rdata_i (mmio_rdata)
  );

  // console, exit and cycle counter registers
  mmio_regs mmio_regs_i (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .req_i           (mmio_req),
    .rdata_o         (mmio_rdata),
    .console_valid_o (console_valid_o),
    .console_char_o  (console_char_o),
    .exit_valid_o    (exit_valid_o),
    .exit_code_o     (exit_code_o)
  );

endmodule

/* verif/tb_mem_subsys.sv */
// directed testbench for the memory subsystem top level
// drives fetch and data requests, keeps a byte model of the RAM and checks every response
// compiled through the file list and run by the simulation script in the project root

`timescale 1ns/1ps

module tb_mem_subsys;
  import mem_pkg::*;

  localparam int          RAM_AW         = RAM_ADDR_WIDTH_DEF;
  localparam logic [31:0] RAM_BYTES      = 32'd1 << RAM_AW;
  // the tests need a few hundred cycles and the limit leaves a wide margin
  localparam int          TIMEOUT_CYCLES = 2000;

  logic        clk;
  logic        rst_n;
  fetch_req_t  fetch_req;
  logic [31:0] fetch_rdata;
  data_req_t   data_req;
  data_rsp_t   data_rsp;
  logic        console_valid;
  logic [7:0]  console_char;
  logic        exit_valid;
  logic [31:0] exit_code;

  int          mismatches;
  int          failures;
  // byte model of the RAM and the word addresses that the read-back test wrote
  logic [7:0]  ram_model [int];
  logic [31:0] checked_addrs [$];

  mem_subsys_top #(
    .RAM_ADDR_WIDTH (RAM_AW)
  ) mem_subsys_top_i (
    .clk_i           (clk),
    .rst_n_i         (rst_n),
    .fetch_req_i     (fetch_req),
    .fetch_rdata_o   (fetch_rdata),
    .data_req_i      (data_req),
    .data_rsp_o      (data_rsp),
    .console_valid_o (console_valid),
    .console_char_o  (console_char),
    .exit_valid_o    (exit_valid),
    .exit_code_o     (exit_code)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  // every drive point sits 1 ns after a rising edge
  task automatic wait_cycle();
    @(posedge clk);
    #1;
  endtask

  function automatic logic [31:0] model_word(input logic [31:0] addr);
    logic [31:0] word;
    int          base;
    base = int'({addr[RAM_AW-1:2], 2'b00});
    for (int b = 0; b < 4; b++) begin
      word[8*b +: 8] = ram_model.exists(base + b) ? ram_model[base + b] : 8'hxx;
    end
    return word;
  endfunction

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      mismatches++;
      $display("mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      mismatches++;
      $display("mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_rsp(input string name, input data_rsp_t got, input data_rsp_t exp);
    if (got !== exp) begin
      mismatches++;
      $display("mismatch %s: got rvalid %h rdata %h err %h expected rvalid %h rdata %h err %h",
               name, got.rvalid, got.rdata, got.err, exp.rvalid, exp.rdata, exp.err);
    end
  endtask

  task automatic check_console(input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      mismatches++;
      $display("mismatch console_char_o: got %h expected %h", got, exp);
    end
  endtask

  // a write takes one edge and the model follows only for RAM addresses and enabled bytes
  task automatic data_write(input logic [31:0] addr, input logic [3:0] be,
                            input logic [31:0] wdata);
    data_req = '{en: 1'b1, we: 1'b1, be: be, addr: addr, wdata: wdata};
    wait_cycle();
    data_req.en = 1'b0;
    if (addr < RAM_BYTES) begin
      for (int b = 0; b < 4; b++) begin
        if (be[b]) ram_model[int'({addr[RAM_AW-1:2], 2'b00}) + b] = wdata[8*b +: 8];
      end
    end
  endtask

  // the response comes one cycle after the request edge and must then drop again
  task automatic data_read(input logic [31:0] addr, output data_rsp_t rsp);
    data_req = '{en: 1'b1, we: 1'b0, be: 4'hf, addr: addr, wdata: 32'h0};
    wait_cycle();
    rsp         = data_rsp;
    data_req.en = 1'b0;
    wait_cycle();
    if (data_rsp.rvalid !== 1'b0) begin
      failures++;
      $display("rvalid stayed high for more than one cycle after the read of %h", addr);
    end
  endtask

  task automatic fetch_word(input logic [31:0] addr, output logic [31:0] word);
    fetch_req = '{en: 1'b1, addr: addr};
    wait_cycle();
    word         = fetch_rdata;
    fetch_req.en = 1'b0;
  endtask

  // a full word first so every byte is known and then a partial write at an unaligned address
  task automatic test_ram_rw();
    logic [31:0] addr;
    data_rsp_t   rsp;
    data_rsp_t   exp;
    for (int i = 0; i < 20; i++) begin
      addr = 32'($urandom_range(0, RAM_BYTES / 4 - 1)) << 2;
      data_write(addr, 4'hf, $urandom);
      data_write(addr | 32'($urandom_range(0, 3)), 4'($urandom_range(1, 15)), $urandom);
      data_read(addr, rsp);
      exp = '{rvalid: 1'b1, rdata: model_word(addr), err: 1'b0};
      check_rsp("data_rsp_o ram read", rsp, exp);
      checked_addrs.push_back(addr);
    end
  endtask

  // fetches alias modulo the RAM size and hold their word while en is low
  task automatic test_fetch();
    logic [31:0] addr;
    logic [31:0] word;
    for (int i = 0; i < 8; i++) begin
      addr = 32'($urandom_range(0, RAM_BYTES / 4 - 1)) << 2;
      data_write(addr, 4'hf, $urandom);
      fetch_word(addr, word);
      check_word("fetch_rdata_o", word, model_word(addr));
      fetch_word(addr + (32'($urandom_range(1, 255)) << RAM_AW) + 32'($urandom_range(0, 3)), word);
      check_word("fetch_rdata_o wrapped", word, model_word(addr));
    end
    data_write(addr, 4'hf, ~word);
    repeat (3) wait_cycle();
    check_word("fetch_rdata_o held", fetch_rdata, word);
  endtask

  // a fetch and a data write to one word on the same edge see the old contents
  task automatic test_collision();
    logic [31:0] addr;
    logic [31:0] old_word;
    logic [31:0] new_word;
    logic [31:0] word;
    addr     = 32'($urandom_range(0, RAM_BYTES / 4 - 1)) << 2;
    old_word = $urandom;
    new_word = ~old_word;
    data_write(addr, 4'hf, old_word);
    fetch_req = '{en: 1'b1, addr: addr};
    data_write(addr, 4'hf, new_word);
    fetch_req.en = 1'b0;
    check_word("fetch_rdata_o collision", fetch_rdata, old_word);
    fetch_word(addr, word);
    check_word("fetch_rdata_o after collision", word, new_word);
  endtask

  task automatic test_console_exit();
    logic [31:0] wdata;
    logic [31:0] code;
    data_rsp_t   rsp;
    data_rsp_t   exp;
    for (int i = 0; i < 4; i++) begin
      wdata = $urandom;
      data_write(MMIO_BASE + 32'(CONSOLE_OFS), 4'h1, wdata);
      check_flag("console_valid_o pulse", console_valid, 1'b1);
      check_console(console_char, wdata[7:0]);
      wait_cycle();
      check_flag("console_valid_o after pulse", console_valid, 1'b0);
    end
    // without byte lane 0 the console takes no character
    data_write(MMIO_BASE + 32'(CONSOLE_OFS), 4'h2, $urandom);
    check_flag("console_valid_o without lane 0", console_valid, 1'b0);
    data_read(MMIO_BASE + 32'(CONSOLE_OFS), rsp);
    exp = '{rvalid: 1'b1, rdata: {24'h0, wdata[7:0]}, err: 1'b0};
    check_rsp("data_rsp_o console read", rsp, exp);
    check_flag("exit_valid_o before exit", exit_valid, 1'b0);
    code = $urandom;
    data_write(MMIO_BASE + 32'(EXIT_OFS), 4'hf, code);
    data_write(MMIO_BASE + 32'(EXIT_OFS), 4'hf, ~code);
    check_flag("exit_valid_o", exit_valid, 1'b1);
    check_word("exit_code_o", exit_code, code);
    data_read(MMIO_BASE + 32'(EXIT_OFS), rsp);
    exp = '{rvalid: 1'b1, rdata: code, err: 1'b0};
    check_rsp("data_rsp_o exit read", rsp, exp);
  endtask

  // the two request edges lie n cycles apart and data_read itself spends two of them
  task automatic test_cycle_counter();
    data_rsp_t first;
    data_rsp_t second;
    int        n;
    n = int'($urandom_range(5, 40));
    data_read(MMIO_BASE + 32'(CYCLE_OFS), first);
    repeat (n - 2) wait_cycle();
    data_read(MMIO_BASE + 32'(CYCLE_OFS), second);
    check_flag("data_rsp_o.rvalid cycle read", first.rvalid & second.rvalid, 1'b1);
    check_flag("data_rsp_o.err cycle read", first.err | second.err, 1'b0);
    check_word("data_rsp_o.rdata cycle difference", second.rdata - first.rdata, 32'(n));
  endtask

  task automatic test_unmapped();
    data_rsp_t   rsp;
    data_rsp_t   exp;
    logic [31:0] bad_addr [3];
    bad_addr[0] = RAM_BYTES;
    bad_addr[1] = MMIO_BASE + MMIO_SPAN;
    bad_addr[2] = 32'h2000_0000 | (32'($urandom_range(0, 255)) << 2);
    exp = '{rvalid: 1'b1, rdata: 32'h0, err: 1'b1};
    foreach (bad_addr[i]) begin
      data_read(bad_addr[i], rsp);
      check_rsp("data_rsp_o unmapped read", rsp, exp);
    end
    // these writes alias the checked words in their low bits and must be dropped
    foreach (checked_addrs[i]) data_write(checked_addrs[i] + RAM_BYTES, 4'hf, $urandom);
    foreach (checked_addrs[i]) begin
      data_read(checked_addrs[i], rsp);
      exp = '{rvalid: 1'b1, rdata: model_word(checked_addrs[i]), err: 1'b0};
      check_rsp("data_rsp_o after unmapped write", rsp, exp);
    end
  endtask

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("timeout after %0d cycles, the tests did not finish", TIMEOUT_CYCLES);
    $display("Verification failed");
    $finish;
  end

  initial begin
    mismatches = 0;
    failures   = 0;
    void'($urandom(32'h96b9));
    rst_n     = 1'b0;
    fetch_req = '0;
    data_req  = '0;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_flag("data_rsp_o.rvalid after reset", data_rsp.rvalid, 1'b0);
    check_flag("data_rsp_o.err after reset", data_rsp.err, 1'b0);
    check_flag("console_valid_o after reset", console_valid, 1'b0);
    test_ram_rw();
    test_fetch();
    test_collision();
    test_console_exit();
    test_cycle_counter();
    test_unmapped();
    $display("result: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* flist.f */
common/mem_pkg.sv
ram/dp_ram.sv
source/data_port_router.sv
periph/mmio_regs.sv
source/mem_subsys_top.sv
verif/tb_mem_subsys.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compiles the memory subsystem testbench with Verilator and runs it
# the exit status is nonzero when the simulation reports a failure
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -f flist.f --top-module tb_mem_subsys -o tb_mem_subsys
./obj_dir/tb_mem_subsys 2>&1 | tee "$LOG"

if grep -q "Verification failed" "$LOG"; then
  echo "simulation reported a failure, see $LOG"
  exit 1
fi

echo "simulation finished without failure"
exit 0
